/* design/l0_prefetch_pkg.sv */
// Shared types of the L0 instruction prefetch buffer.
// The line width is fixed at four 32-bit words; the realignment logic
// relies on exactly this width.
`default_nettype none

package l0_prefetch_pkg;

  // number of 32-bit words in one memory line
  localparam int unsigned WORDS_PER_LINE = 4;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;

  // one 128-bit memory line, word 0 at the lowest address
  typedef instr_t [WORDS_PER_LINE-1:0] fetch_line_t;

  // line request toward instruction memory, addr is line aligned
  typedef struct packed {
    logic  req;
    addr_t addr;
  } mem_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    fetch_line_t rdata;
  } mem_rsp_t;

  // fetcher status seen by controller and aligner
  typedef struct packed {
    logic  fetch_gnt;
    logic  fetch_valid;
    logic  valid;
    addr_t line_addr;
  } line_status_t;

  // instruction shape at the current address
  typedef struct packed {
    logic is_compressed;
    logic is_crossword;
    logic next_is_crossword;
    logic next_upper_compressed;
    logic fetch_possible;
  } align_flags_t;

  typedef struct packed {
    logic use_last;
    logic save_last;
  } ctrl_cmd_t;

endpackage

`default_nettype wire

/* design/l0_line_fetch.sv */
// Memory-side line fetcher. At most one line request is outstanding.
// rvalid data is passed straight through in the cycle it arrives.
`timescale 1ns/1ps
`default_nettype none

module l0_line_fetch import l0_prefetch_pkg::*; (
  input  wire logic         clk,
  input  wire logic         rst_n,
  input  wire logic         fetch_i,
  input  wire addr_t        fetch_addr_i,
  input  wire logic         branch_i,
  input  wire addr_t        branch_addr_i,
  output mem_req_t          mem_req_o,
  input  wire mem_rsp_t     mem_rsp_i,
  output line_status_t      status_o,
  output fetch_line_t       line_o,
  output logic              busy_o
);

  typedef enum logic [2:0] {
    ls_empty, ls_valid, ls_wait_gnt, ls_wait_rvalid, ls_aborted_branch
  } line_state_e;

  line_state_e state_q, state_d;
  fetch_line_t line_q;
  addr_t       addr_q, req_addr;
  logic        req, valid, fetch_valid;

  ////////////////////////////////////////////////////////////
  // request state machine
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    req         = 1'b0;
    valid       = 1'b0;
    fetch_valid = 1'b0;

    // a pending request keeps its address unless a branch overrides it
    if (branch_i) begin
      req_addr = branch_addr_i;
    end else if (state_q == ls_wait_gnt || state_q == ls_aborted_branch) begin
      req_addr = addr_q;
    end else begin
      req_addr = fetch_addr_i;
    end

    case (state_q)
      ls_empty, ls_valid: begin
        valid = (state_q == ls_valid);
        if (branch_i || fetch_i) begin
          req     = 1'b1;
          state_d = mem_rsp_i.gnt ? ls_wait_rvalid : ls_wait_gnt;
        end
      end
      ls_wait_gnt: begin
        req = 1'b1;
        if (mem_rsp_i.gnt) begin
          state_d = ls_wait_rvalid;
        end
      end
      ls_wait_rvalid: begin
        valid       = mem_rsp_i.rvalid;
        fetch_valid = mem_rsp_i.rvalid && !branch_i;
        if (mem_rsp_i.rvalid) begin
          // overlap the next request with the returning line
          if (branch_i || fetch_i) begin
            req     = 1'b1;
            state_d = mem_rsp_i.gnt ? ls_wait_rvalid : ls_wait_gnt;
          end else begin
            state_d = ls_valid;
          end
        end else if (branch_i) begin
          state_d = ls_aborted_branch;
        end
      end
      ls_aborted_branch: begin
        // drop the stale line, then reissue toward the branch target
        if (mem_rsp_i.rvalid) begin
          req     = 1'b1;
          state_d = mem_rsp_i.gnt ? ls_wait_rvalid : ls_wait_gnt;
        end
      end
      default: state_d = ls_empty;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ls_empty;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      if (branch_i || req) begin
        addr_q <= req_addr;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_rsp_i.rvalid) begin
      line_q <= mem_rsp_i.rdata;
    end
  end

  assign mem_req_o = '{req: req, addr: {req_addr[31:4], 4'h0}};
  assign line_o    = mem_rsp_i.rvalid ? mem_rsp_i.rdata : line_q;
  assign status_o  = '{fetch_gnt:   mem_rsp_i.gnt && req,
                       fetch_valid: fetch_valid,
                       valid:       valid && !branch_i,
                       line_addr:   addr_q};
  assign busy_o    = (state_q != ls_empty && state_q != ls_valid) || req;

  // prefetch addresses arrive line aligned
  a_fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_i |-> fetch_addr_i[3:0] == 4'h0);
  // line requests are held until granted
  a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_o.req && !mem_rsp_i.gnt |=> mem_req_o.req);

endmodule

`default_nettype wire

/* design/l0_instr_align.sv */
// Halfword realignment of instructions out of the current line.
// Addresses are assumed even. The saved word holds the upper word of
// the previous line for instructions that cross a line boundary.
`timescale 1ns/1ps
`default_nettype none

module l0_instr_align import l0_prefetch_pkg::*; (
  input  wire logic         clk,
  input  wire logic         rst_n,
  input  wire addr_t        addr_i,
  input  wire fetch_line_t  line_i,
  input  wire logic         valid_i,
  input  wire ctrl_cmd_t    cmd_i,
  output align_flags_t      flags_o,
  output instr_t            rdata_o
);

  instr_t     last_q;
  instr_t     word, upper_word, unaligned;
  logic [1:0] next_idx;
  logic       aligned_c, unaligned_c, upper_c;

  assign next_idx   = addr_i[3:2] + 2'd1;
  assign word       = cmd_i.use_last ? last_q : line_i[addr_i[3:2]];
  assign upper_word = cmd_i.use_last ? last_q : line_i[WORDS_PER_LINE-1];

  // upper half of the addressed word plus lower half of the following one
  assign unaligned = {line_i[next_idx][15:0], word[31:16]};
  assign rdata_o   = addr_i[1] ? unaligned : word;

  assign aligned_c   = word[1:0] != 2'b11;
  assign unaligned_c = word[17:16] != 2'b11;
  assign upper_c     = upper_word[17:16] != 2'b11;

  always_comb begin
    flags_o.is_compressed  = addr_i[1] ? unaligned_c : aligned_c;
    flags_o.is_crossword   = (addr_i[3:1] == 3'b111) && !upper_c;
    // the next instruction starts at the last halfword of the line
    flags_o.next_is_crossword =
      ((addr_i[3:1] == 3'b110) && aligned_c && !upper_c) ||
      ((addr_i[3:1] == 3'b101) && !unaligned_c && !upper_c);
    flags_o.next_upper_compressed =
      ((addr_i[3:1] == 3'b110) && aligned_c && upper_c) ||
      ((addr_i[3:1] == 3'b101) && !unaligned_c && upper_c);
    flags_o.fetch_possible = addr_i[3:2] == 2'b11;
  end

  always_ff @(posedge clk) begin
    if (cmd_i.save_last) begin
      last_q <= line_i[WORDS_PER_LINE-1];
    end
  end

  // two crossword accesses cannot follow each other
  a_no_double_cross: assert property (@(posedge clk) disable iff (!rst_n)
    valid_i |-> !(flags_o.is_crossword && flags_o.next_is_crossword));

endmodule

`default_nettype wire

/* design/l0_prefetch_ctrl.sv */
// Core-side control of the prefetch buffer. Branch targets must be even.
// A branch strobe always wins and needs no handshake.
`timescale 1ns/1ps
`default_nettype none

module l0_prefetch_ctrl import l0_prefetch_pkg::*; (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire logic          branch_i,
  input  wire addr_t         branch_addr_i,
  input  wire logic          ready_i,
  input  wire line_status_t  status_i,
  input  wire align_flags_t  flags_i,
  output logic               fetch_o,
  output addr_t              fetch_addr_o,
  output ctrl_cmd_t          cmd_o,
  output addr_t              addr_o,
  output logic               valid_o
);

  typedef enum logic [3:0] {
    cs_idle, cs_branched, cs_not_valid, cs_not_valid_gnt, cs_not_valid_cross,
    cs_not_valid_cross_gnt, cs_valid, cs_valid_cross, cs_valid_gnt,
    cs_valid_fetch_done
  } ctrl_state_e;

  ctrl_state_e state_q, state_d;
  addr_t       addr_q, addr_d;
  logic        valid, accept, next_valid, use_last, save_last;
  logic        gnt, nxc, nuc;

  assign gnt        = status_i.fetch_gnt;
  assign nxc        = flags_i.next_is_crossword;
  assign nuc        = flags_i.next_upper_compressed;
  assign accept     = ready_i && valid;
  assign next_valid = ((addr_q[3:2] != 2'b11) || nuc) && !nxc && valid;

  ////////////////////////////////////////////////////////////
  // core-side state machine
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    fetch_o   = 1'b0;
    use_last  = 1'b0;
    save_last = 1'b0;
    valid     = 1'b0;
    case (state_q)
      cs_branched: begin
        fetch_o = flags_i.fetch_possible;
        valid   = status_i.fetch_valid && !flags_i.is_crossword;
        if (accept) begin
          if (next_valid) begin
            save_last = gnt;
            state_d   = gnt ? cs_valid_gnt : cs_valid;
          end else if (nxc) begin
            save_last = gnt;
            state_d   = gnt ? cs_not_valid_cross_gnt : cs_not_valid_cross;
          end else begin
            state_d = gnt ? cs_not_valid_gnt : cs_not_valid;
          end
        end else if (status_i.fetch_valid) begin
          save_last = flags_i.is_crossword || gnt;
          if (flags_i.is_crossword) begin
            state_d = gnt ? cs_not_valid_cross_gnt : cs_not_valid_cross;
          end else begin
            state_d = gnt ? cs_valid_gnt : cs_valid;
          end
        end
      end
      cs_not_valid: begin
        fetch_o = 1'b1;
        if (gnt) state_d = cs_not_valid_gnt;
      end
      cs_not_valid_gnt: begin
        valid = status_i.fetch_valid;
        if (status_i.fetch_valid) state_d = cs_valid;
      end
      cs_not_valid_cross: begin
        fetch_o   = 1'b1;
        save_last = gnt;
        if (gnt) state_d = cs_not_valid_cross_gnt;
      end
      cs_not_valid_cross_gnt: begin
        valid    = status_i.fetch_valid;
        use_last = 1'b1;
        if (status_i.fetch_valid) state_d = accept ? cs_valid : cs_valid_cross;
      end
      cs_valid: begin
        valid   = 1'b1;
        fetch_o = flags_i.fetch_possible;
        if (accept) begin
          if (nxc) begin
            save_last = gnt;
            state_d   = gnt ? cs_not_valid_cross_gnt : cs_not_valid_cross;
          end else if (!next_valid) begin
            state_d = gnt ? cs_not_valid_gnt : cs_not_valid;
          end else if (gnt && nuc) begin
            save_last = 1'b1;
            state_d   = cs_valid_gnt;
          end
        end else if (gnt) begin
          save_last = 1'b1;
          state_d   = cs_valid_gnt;
        end
      end
      cs_valid_cross: begin
        valid    = 1'b1;
        use_last = 1'b1;
        if (accept) state_d = cs_valid;
      end
      cs_valid_gnt: begin
        valid    = 1'b1;
        use_last = 1'b1;
        if (accept && status_i.fetch_valid) begin
          state_d = nxc ? cs_valid_cross : (nuc ? cs_valid_fetch_done : cs_valid);
        end else if (accept) begin
          state_d = nxc ? cs_not_valid_cross_gnt : (nuc ? cs_valid_gnt : cs_not_valid_gnt);
        end else if (status_i.fetch_valid) begin
          state_d = cs_valid_fetch_done;
        end
      end
      cs_valid_fetch_done: begin
        valid    = 1'b1;
        use_last = 1'b1;
        if (accept) begin
          state_d = nxc ? cs_valid_cross : (nuc ? cs_valid_fetch_done : cs_valid);
        end
      end
      default: ;
    endcase
    if (branch_i) state_d = cs_branched;
  end

  // step by the length of the accepted instruction
  always_comb begin
    if (branch_i) begin
      addr_d = branch_addr_i;
    end else if (accept) begin
      addr_d = addr_q + (flags_i.is_compressed ? 32'd2 : 32'd4);
    end else begin
      addr_d = addr_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= cs_idle;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
    end
  end

  assign fetch_addr_o = {addr_q[31:4] + 28'd1, 4'h0};
  assign cmd_o        = '{use_last: use_last, save_last: save_last};
  assign addr_o       = addr_q;
  assign valid_o      = valid && !branch_i;

  a_ready_valid: assert property (@(posedge clk) disable iff (!rst_n)
    ready_i |-> valid_o);
  // outside the saved-line states the fetcher line is the addressed line
  a_line_match: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == cs_valid) && status_i.valid |->
      addr_q[31:4] == status_i.line_addr[31:4]);

endmodule

`default_nettype wire

/* design/l0_prefetch_buffer.sv */
// L0 prefetch buffer for a RISC-V fetch stage with a 128-bit memory port.
// Nothing is fetched before the first branch strobe after reset.
`timescale 1ns/1ps
`default_nettype none

module l0_prefetch_buffer import l0_prefetch_pkg::*; (
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      branch_i,
  input  wire addr_t     addr_i,
  input  wire logic      ready_i,
  output logic           valid_o,
  output instr_t         rdata_o,
  output addr_t          addr_o,
  output mem_req_t       mem_req_o,
  input  wire mem_rsp_t  mem_rsp_i,
  output logic           busy_o
);

  line_status_t line_status;
  fetch_line_t  cur_line;
  align_flags_t flags;
  ctrl_cmd_t    cmd;
  logic         do_fetch;
  addr_t        fetch_addr;

  l0_line_fetch u_line_fetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_i       (do_fetch),
    .fetch_addr_i  (fetch_addr),
    .branch_i      (branch_i),
    .branch_addr_i (addr_i),
    .mem_req_o     (mem_req_o),
    .mem_rsp_i     (mem_rsp_i),
    .status_o      (line_status),
    .line_o        (cur_line),
    .busy_o        (busy_o)
  );

  l0_instr_align u_instr_align (
    .clk     (clk),
    .rst_n   (rst_n),
    .addr_i  (addr_o),
    .line_i  (cur_line),
    .valid_i (line_status.valid),
    .cmd_i   (cmd),
    .flags_o (flags),
    .rdata_o (rdata_o)
  );

  l0_prefetch_ctrl u_prefetch_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (addr_i),
    .ready_i       (ready_i),
    .status_i      (line_status),
    .flags_i       (flags),
    .fetch_o       (do_fetch),
    .fetch_addr_o  (fetch_addr),
    .cmd_o         (cmd),
    .addr_o        (addr_o),
    .valid_o       (valid_o)
  );

endmodule

`default_nettype wire

/* testbench/l0_prefetch_checker.sv */
// Reference model of the instruction stream, read from the image in the testbench top.
// An instruction is 32 bits wide when its low two bits are both ones.
`timescale 1ns/1ps
`default_nettype none

module l0_prefetch_checker import l0_prefetch_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     idle_check_i,
  input  wire logic     branch_i,
  input  wire addr_t    branch_addr_i,
  input  wire logic     valid_i,
  input  wire logic     ready_i,
  input  wire addr_t    addr_i,
  input  wire instr_t   rdata_i,
  input  wire mem_req_t mem_req_i,
  input  wire logic     mem_gnt_i,
  input  wire logic     busy_i,
  output int            accepted_o,
  output int            crosswords_o,
  output int            stream_errs_o,
  output int            req_errs_o
);

  addr_t pc;
  logic  started;
  // granted requests per line since the last branch
  int    req_cnt [0:255];

  function automatic logic [15:0] half_at(input addr_t a);
    logic [31:0] word;
    word = tb_l0_prefetch.mem_image[a[11:2]];
    return a[1] ? word[31:16] : word[15:0];
  endfunction

  always @(posedge clk) begin : compare
    logic [15:0] lo;
    logic [15:0] hi;
    logic        compressed;
    instr_t      expected;
    instr_t      mask;
    if (!rst_n) begin
      pc            = '0;
      started       = 1'b0;
      accepted_o    = 0;
      crosswords_o  = 0;
      stream_errs_o = 0;
      req_errs_o    = 0;
      foreach (req_cnt[i]) req_cnt[i] = 0;
    end else begin
      if (idle_check_i && (valid_i || mem_req_i.req || busy_i)) begin
        $display("CHECK FAILED at %t: valid_o %b, mem_req_o.req %b, busy_o %b before any branch",
                 $realtime, valid_i, mem_req_i.req, busy_i);
        stream_errs_o++;
      end
      if (mem_req_i.req && !busy_i) begin
        $display("CHECK FAILED at %t: busy_o low while mem_req_o.req is high", $realtime);
        req_errs_o++;
      end
      if (mem_req_i.req && mem_req_i.addr[3:0] != 4'h0) begin
        $display("CHECK FAILED at %t: request address 0x%08h not line aligned",
                 $realtime, mem_req_i.addr);
        req_errs_o++;
      end
      if (branch_i) begin
        if (valid_i) begin
          $display("CHECK FAILED at %t: valid_o high during the branch strobe", $realtime);
          stream_errs_o++;
        end
        pc      = branch_addr_i;
        started = 1'b1;
        foreach (req_cnt[i]) req_cnt[i] = 0;
      end else if (valid_i && ready_i) begin
        lo         = half_at(pc);
        hi         = half_at(pc + 32'd2);
        compressed = lo[1:0] != 2'b11;
        expected   = compressed ? {16'h0, lo} : {hi, lo};
        mask       = compressed ? 32'h0000_ffff : 32'hffff_ffff;
        if (!started) begin
          $display("instruction accepted at %t before any branch", $realtime);
          stream_errs_o++;
        end else if (addr_i != pc) begin
          $display("CHECK FAILED at %t: addr_o 0x%08h, expected 0x%08h", $realtime, addr_i, pc);
          stream_errs_o++;
        end else if ((rdata_i & mask) != expected) begin
          $display("CHECK FAILED at %t: rdata_o 0x%08h at 0x%08h, expected 0x%08h",
                   $realtime, rdata_i & mask, pc, expected);
          stream_errs_o++;
        end
        if (req_cnt[pc[11:4]] > 2 ||
            (!compressed && pc[3:1] == 3'b111 && req_cnt[pc[11:4] + 8'd1] > 2)) begin
          $display("CHECK FAILED at %t: line of 0x%08h requested more than twice", $realtime, pc);
          req_errs_o++;
        end
        if (!compressed && pc[3:1] == 3'b111) crosswords_o++;
        pc = pc + (compressed ? 32'd2 : 32'd4);
        accepted_o++;
      end
      if (mem_req_i.req && mem_gnt_i) req_cnt[mem_req_i.addr[11:4]]++;
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_l0_prefetch.sv */
// Testbench for the L0 prefetch buffer against a random 4 KiB memory image.
// Addresses wrap at 4 KiB in the memory model and in the checker.
// ready_i is only raised while valid_o is high.
`timescale 1ns/1ps
`default_nettype none

module tb_l0_prefetch import l0_prefetch_pkg::*; ();

  localparam real CLK_HALF      = 2.0;
  localparam real DRIVE_DLY     = 0.5;
  localparam int  RST_CYCLES    = 5;
  localparam int  IDLE_CYCLES   = 20;
  localparam int  N_ALIGNED     = 4;
  localparam int  ALIGNED_LIMIT = 1500;
  localparam int  N_ODD         = 30;
  localparam int  ODD_LIMIT     = 300;
  localparam int  N_ABORT       = 40;
  localparam int  ABORT_GAP     = 8;
  localparam int  RECOVER_LIMIT = 1000;
  // total of all test budgets plus a quarter margin
  localparam int  WATCHDOG_CYCLES = (RST_CYCLES + IDLE_CYCLES + N_ALIGNED * ALIGNED_LIMIT +
    N_ODD * ODD_LIMIT + N_ABORT * 2 * ABORT_GAP + RECOVER_LIMIT) * 5 / 4;

  logic        clk = 1'b0;
  logic        rst_n, branch, ready_en, rand_ready, idle_check;
  logic        ready, valid, busy, mem_gnt, mem_rvalid;
  addr_t       branch_addr, addr;
  instr_t      rdata;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  fetch_line_t mem_line;
  integer      seed = 32'h7edf4f84;
  int          accepted, crosswords, stream_errs, req_errs, tb_errs, failed_tests;

  // memory image and model state
  logic [31:0] mem_image [0:1023];
  logic        pend;
  addr_t       pend_addr;
  int          gnt_wait, rv_wait;

  always #CLK_HALF clk = ~clk;

  assign ready      = ready_en && valid;
  assign mem_rvalid = pend && (rv_wait == 1);
  assign mem_gnt    = mem_req.req && (gnt_wait == 0) && (!pend || mem_rvalid);
  assign mem_line   = {mem_image[{pend_addr[11:4], 2'd3}], mem_image[{pend_addr[11:4], 2'd2}],
                       mem_image[{pend_addr[11:4], 2'd1}], mem_image[{pend_addr[11:4], 2'd0}]};
  assign mem_rsp    = '{gnt: mem_gnt, rvalid: mem_rvalid, rdata: mem_line};

  l0_prefetch_buffer UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .branch_i  (branch),
    .addr_i    (branch_addr),
    .ready_i   (ready),
    .valid_o   (valid),
    .rdata_o   (rdata),
    .addr_o    (addr),
    .mem_req_o (mem_req),
    .mem_rsp_i (mem_rsp),
    .busy_o    (busy)
  );

  l0_prefetch_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .idle_check_i  (idle_check),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .valid_i       (valid),
    .ready_i       (ready),
    .addr_i        (addr),
    .rdata_i       (rdata),
    .mem_req_i     (mem_req),
    .mem_gnt_i     (mem_gnt),
    .busy_i        (busy),
    .accepted_o    (accepted),
    .crosswords_o  (crosswords),
    .stream_errs_o (stream_errs),
    .req_errs_o    (req_errs)
  );

  //////////////////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////////////////

  // grant after 0 to 3 cycles, line returns 1 to 3 cycles after the grant
  always begin : mem_model
    logic  granted, returned, requesting;
    addr_t gaddr;
    int    next_gnt, next_rv;
    @(posedge clk);
    granted    = mem_gnt;
    returned   = mem_rvalid;
    requesting = mem_req.req;
    gaddr      = mem_req.addr;
    next_gnt   = $unsigned($random(seed)) % 4;
    next_rv    = 1 + $unsigned($random(seed)) % 3;
    #DRIVE_DLY;
    if (!rst_n) begin
      pend     = 1'b0;
      gnt_wait = 0;
      rv_wait  = 0;
    end else begin
      if (returned) pend = 1'b0;
      else if (pend) rv_wait = rv_wait - 1;
      if (granted) begin
        pend      = 1'b1;
        pend_addr = gaddr;
        rv_wait   = next_rv;
        gnt_wait  = next_gnt;
      end else if (requesting && gnt_wait > 0) begin
        gnt_wait = gnt_wait - 1;
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
    branch = 1'b0;
    if (rand_ready) ready_en = ($random(seed) & 3) != 0;
  endtask

  task automatic take_branch(input addr_t target);
    branch      = 1'b1;
    branch_addr = target;
    next_cycle();
  endtask

  task automatic wait_accepts(input int n, input int limit);
    int start;
    int cycles;
    start  = accepted;
    cycles = 0;
    while (accepted - start < n && cycles < limit) begin
      next_cycle();
      cycles++;
    end
    if (accepted - start < n) begin
      $display("stream stalled at %t: only %0d of %0d instructions accepted in %0d cycles",
               $realtime, accepted - start, n, limit);
      tb_errs++;
    end
  endtask

  task automatic finish_test(input int num, input string name, input int errs);
    if (errs == 0) begin
      $display("test %0d %s: pass", num, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: fail with %0d errors", num, name, errs);
    end
  endtask

  initial begin
    int base;
    int cross_base;
    int gap;
    $timeformat(-9, 1, " ns", 0);
    for (int i = 0; i < 1024; i++) mem_image[i] = $random(seed);
    rst_n        = 1'b0;
    branch       = 1'b0;
    branch_addr  = '0;
    ready_en     = 1'b0;
    rand_ready   = 1'b0;
    idle_check   = 1'b0;
    pend         = 1'b0;
    pend_addr    = '0;
    gnt_wait     = 0;
    rv_wait      = 0;
    tb_errs      = 0;
    failed_tests = 0;
    repeat (RST_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;

    base       = stream_errs + tb_errs;
    idle_check = 1'b1;
    repeat (IDLE_CYCLES) next_cycle();
    idle_check = 1'b0;
    finish_test(1, "idle after reset", stream_errs + tb_errs - base);

    base     = stream_errs + tb_errs;
    ready_en = 1'b1;
    for (int n = 0; n < N_ALIGNED; n++) begin
      take_branch({20'h0, 8'($random(seed)), 4'h0});
      wait_accepts(200, ALIGNED_LIMIT);
    end
    finish_test(2, "aligned stream, ready high", stream_errs + tb_errs - base);

    base       = stream_errs + tb_errs;
    cross_base = crosswords;
    rand_ready = 1'b1;
    for (int n = 0; n < N_ODD; n++) begin
      // every third target sits on the last halfword of a line
      if (n % 3 == 0) take_branch({20'h0, 8'($random(seed)), 4'he});
      else take_branch({20'h0, 10'($random(seed)), 2'b10});
      wait_accepts(10 + $unsigned($random(seed)) % 30, ODD_LIMIT);
    end
    if (crosswords == cross_base) begin
      $display("no instruction crossed a line boundary in test 3");
      tb_errs++;
    end
    finish_test(3, "odd targets, random ready", stream_errs + tb_errs - base);

    base = stream_errs + tb_errs;
    for (int n = 0; n < N_ABORT; n++) begin
      gap = 0;
      while (!busy && gap < ABORT_GAP) begin
        next_cycle();
        gap++;
      end
      take_branch({20'h0, 11'($random(seed)), 1'b0});
      repeat ($unsigned($random(seed)) % ABORT_GAP) next_cycle();
    end
    wait_accepts(50, RECOVER_LIMIT);
    finish_test(4, "branches during outstanding fetch", stream_errs + tb_errs - base);

    finish_test(5, "line requests aligned and bounded", req_errs);

    $display("summary: 5 tests, %0d failed, %0d accepted, %0d crosswords, %0d errors",
             failed_tests, accepted, crosswords, stream_errs + req_errs + tb_errs);
    if (failed_tests == 0 && stream_errs + req_errs + tb_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* l0_prefetch.f */
design/l0_prefetch_pkg.sv
design/l0_line_fetch.sv
design/l0_instr_align.sv
design/l0_prefetch_ctrl.sv
design/l0_prefetch_buffer.sv
testbench/l0_prefetch_checker.sv
testbench/tb_l0_prefetch.sv

/* Bender.yml */
package:
  name: l0_prefetch

sources:
  - design/l0_prefetch_pkg.sv
  - design/l0_line_fetch.sv
  - design/l0_instr_align.sv
  - design/l0_prefetch_ctrl.sv
  - design/l0_prefetch_buffer.sv
  - target: test
    files:
      - testbench/l0_prefetch_checker.sv
      - testbench/tb_l0_prefetch.sv
